// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_vadd
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/axil_regs.sv
`timescale 1ns/1ps

module axil_regs (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic [vadd_pkg::AXI_AW-1:0]                         awaddr,
    input  logic                                                awvalid,
    output logic                                                awready,
    input  logic [vadd_pkg::AXI_DW-1:0]                         wdata,
    input  logic                                                wvalid,
    output logic                                                wready,
    output logic [1:0]                                          bresp,
    output logic                                                bvalid,
    input  logic                                                bready,
    input  logic [vadd_pkg::AXI_AW-1:0]                         araddr,
    input  logic                                                arvalid,
    output logic                                                arready,
    output logic [vadd_pkg::AXI_DW-1:0]                         rdata,
    output logic [1:0]                                          rresp,
    output logic                                                rvalid,
    input  logic                                                rready,
    output logic                                                start,
    output logic [vadd_pkg::NUM_LANES-1:0][vadd_pkg::LANE_W-1:0] opa,
    output logic [vadd_pkg::NUM_LANES-1:0][vadd_pkg::LANE_W-1:0] opb,
    input  logic                                                busy,
    input  logic                                                done,
    input  logic [vadd_pkg::NUM_LANES-1:0][vadd_pkg::LANE_W:0]   res
);
    import vadd_pkg::*;

    logic                 wr_accept;
    logic                 rd_accept;
    logic                 wr_ctrl_hit;
    logic                 wr_known;   // Write address is mapped.
    logic                 wr_res_hit;
    logic [NUM_LANES-1:0] wr_opa_hit;
    logic [NUM_LANES-1:0] wr_opb_hit;
    logic [AXI_DW-1:0]    rd_word;
    logic                 rd_known;

    function automatic logic [AXI_AW-1:0] lane_addr(input logic [AXI_AW-1:0] base,
                                                     input int idx);
        return base + AXI_AW'(4 * idx);
    endfunction

    // Address and data are taken together, one response outstanding at a time.
    assign wr_accept = awvalid & wvalid & ~bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign rd_accept = arvalid & ~rvalid;
    assign arready   = rd_accept;

    assign wr_ctrl_hit = (awaddr == REG_CTRL);
    assign start       = wr_accept & wr_ctrl_hit & wdata[0];  // Single-cycle pulse.

    always_comb begin
        wr_opa_hit = '0;
        wr_opb_hit = '0;
        wr_res_hit = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (awaddr == lane_addr(REG_OPA_BASE, i)) wr_opa_hit[i] = 1'b1;
            if (awaddr == lane_addr(REG_OPB_BASE, i)) wr_opb_hit[i] = 1'b1;
            if (awaddr == lane_addr(REG_RES_BASE, i)) wr_res_hit = 1'b1;
        end
        wr_known = wr_ctrl_hit | (awaddr == REG_STATUS) | wr_res_hit |
                   (|wr_opa_hit) | (|wr_opb_hit);  // STATUS and RES accept and ignore.
    end

    // Read mux, all values zero-extended to the bus width.
    always_comb begin
        rd_word  = '0;
        rd_known = 1'b0;
        if (araddr == REG_CTRL) begin
            rd_known = 1'b1;  // Start bit self-clears, reads as zero.
        end
        if (araddr == REG_STATUS) begin
            rd_known = 1'b1;
            rd_word  = AXI_DW'({done, busy});
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (araddr == lane_addr(REG_OPA_BASE, i)) begin
                rd_known = 1'b1;
                rd_word  = AXI_DW'(opa[i]);
            end
            if (araddr == lane_addr(REG_OPB_BASE, i)) begin
                rd_known = 1'b1;
                rd_word  = AXI_DW'(opb[i]);
            end
            if (araddr == lane_addr(REG_RES_BASE, i)) begin
                rd_known = 1'b1;
                rd_word  = AXI_DW'(res[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            opa    <= '0;
            opb    <= '0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (wr_accept) begin
                bvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (rd_accept) begin
                rvalid <= 1'b1;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (wr_accept && wr_opa_hit[i]) opa[i] <= wdata[LANE_W-1:0];  // Low half kept.
                if (wr_accept && wr_opb_hit[i]) opb[i] <= wdata[LANE_W-1:0];
            end
        end
    end

    // Response payload, held while the matching valid waits.
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_known ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_accept) begin
            rdata <= rd_word;
            rresp <= rd_known ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// File: hdl/lane_dispatch.sv
`timescale 1ns/1ps

module lane_dispatch (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                start,
    input  logic [vadd_pkg::NUM_LANES-1:0][vadd_pkg::LANE_W-1:0] opa,
    input  logic [vadd_pkg::NUM_LANES-1:0][vadd_pkg::LANE_W-1:0] opb,
    input  logic                                                all_done,
    output logic                                                busy,
    lane_if.feeder                                              lanes [vadd_pkg::NUM_LANES]
);
    import vadd_pkg::*;

    logic [NUM_LANES-1:0][LANE_W-1:0] snap_a;  // Operands frozen for the run.
    logic [NUM_LANES-1:0][LANE_W-1:0] snap_b;
    logic                             issue_q;
    logic                             launch;

    assign launch = start & ~busy;  // A start during a run is dropped.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_q <= 1'b0;
            busy    <= 1'b0;
        end else begin
            issue_q <= launch;
            if (launch) begin
                busy <= 1'b1;  // Rises together with issue.
            end else if (all_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            snap_a <= opa;
            snap_b <= opb;
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_feed
        assign lanes[i].issue = issue_q;
        assign lanes[i].a     = snap_a[i];
        assign lanes[i].b     = snap_b[i];
    end

endmodule

// File: hdl/lane_if.sv
`timescale 1ns/1ps

interface lane_if;
    import vadd_pkg::*;

    logic              issue;      // Single-cycle launch of one addition.
    logic [LANE_W-1:0] a;
    logic [LANE_W-1:0] b;
    logic [LANE_W:0]   sum;        // Top bit is the carry out.
    logic              sum_valid;

    modport feeder (
        output issue,
        output a,
        output b
    );

    modport adder (
        input  issue,
        input  a,
        input  b,
        output sum,
        output sum_valid
    );

    modport drain (
        input issue,
        input sum,
        input sum_valid
    );

endinterface

// File: hdl/pipe_adder.sv
`timescale 1ns/1ps

module pipe_adder #(
    parameter int WIDTH = vadd_pkg::LANE_W
) (
    input  logic  clk,
    input  logic  rst_n,
    lane_if.adder lane
);
    import vadd_pkg::*;

    logic [WIDTH-1:0]   a_s1;
    logic [WIDTH-1:0]   b_s1;
    logic [WIDTH-1:0]   p_s1;
    logic [WIDTH-1:0]   g_s1;
    logic [WIDTH-1:0]   p_s2;
    logic [WIDTH-1:0]   g_s2;
    logic [WIDTH:0]     c_s2;     // Carry into each bit, plus carry out.
    logic [WIDTH:0]     c_s3;
    logic [WIDTH-1:0]   p_s3;
    logic [WIDTH:0]     sum_s3;
    logic [WIDTH:0]     sum_q;
    logic [ADD_LAT-1:0] vld;      // One bit per register stage.

    // Stage 1 captures the operands.
    always_ff @(posedge clk) begin
        a_s1 <= lane.a;
        b_s1 <= lane.b;
    end

    assign p_s1 = a_s1 ^ b_s1;  // Propagate.
    assign g_s1 = a_s1 & b_s1;  // Generate.

    // Stage 2 holds propagate and generate.
    always_ff @(posedge clk) begin
        p_s2 <= p_s1;
        g_s2 <= g_s1;
    end

    always_comb begin
        c_s2[0] = 1'b0;  // No carry in.
        for (int i = 0; i < WIDTH; i++) begin
            c_s2[i+1] = g_s2[i] | (p_s2[i] & c_s2[i]);
        end
    end

    // Stage 3 holds the carries.
    always_ff @(posedge clk) begin
        c_s3 <= c_s2;
        p_s3 <= p_s2;
    end

    assign sum_s3 = {c_s3[WIDTH], p_s3 ^ c_s3[WIDTH-1:0]};

    // Stage 4 is the output register.
    always_ff @(posedge clk) begin
        sum_q <= sum_s3;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[ADD_LAT-2:0], lane.issue};  // Follows the data stage by stage.
        end
    end

    assign lane.sum       = sum_q;
    assign lane.sum_valid = vld[ADD_LAT-1];

endmodule

// File: hdl/result_collect.sv
`timescale 1ns/1ps

module result_collect (
    input  logic                                              clk,
    input  logic                                              rst_n,
    lane_if.drain                                             lanes [vadd_pkg::NUM_LANES],
    output logic [vadd_pkg::NUM_LANES-1:0][vadd_pkg::LANE_W:0] res,
    output logic                                              done,
    output logic                                              all_done
);
    import vadd_pkg::*;

    logic [NUM_LANES-1:0]           issue_vec;
    logic [NUM_LANES-1:0]           valid_vec;
    logic [NUM_LANES-1:0][LANE_W:0] sum_vec;
    logic [NUM_LANES-1:0]           reported;       // Lanes that delivered this run.
    logic [NUM_LANES-1:0]           reported_next;
    logic                           restart;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_tap
        assign issue_vec[i] = lanes[i].issue;
        assign valid_vec[i] = lanes[i].sum_valid;
        assign sum_vec[i]   = lanes[i].sum;
    end

    assign restart       = |issue_vec;  // A new batch is entering the lanes.
    assign reported_next = reported | valid_vec;
    assign all_done      = (&reported_next) & ~done & ~restart;  // One pulse per run.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reported <= '0;
            done     <= 1'b0;
            res      <= '0;
        end else begin
            if (restart) begin
                reported <= '0;
                done     <= 1'b0;
            end else begin
                reported <= reported_next;
                if (all_done) done <= 1'b1;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (valid_vec[i]) res[i] <= sum_vec[i];
            end
        end
    end

endmodule

// File: hdl/vadd_pkg.sv
package vadd_pkg;

    localparam int LANE_W    = 16;  // Operand width per lane.
    localparam int NUM_LANES = 4;
    localparam int AXI_AW    = 8;
    localparam int AXI_DW    = 32;
    localparam int ADD_LAT   = 4;   // Issue to sum_valid, in cycles.

    // Register map.
    localparam logic [AXI_AW-1:0] REG_CTRL     = 8'h00;  // Bit 0 requests a start.
    localparam logic [AXI_AW-1:0] REG_STATUS   = 8'h04;  // Bit 0 busy, bit 1 done.
    localparam logic [AXI_AW-1:0] REG_OPA_BASE = 8'h10;
    localparam logic [AXI_AW-1:0] REG_OPB_BASE = 8'h20;
    localparam logic [AXI_AW-1:0] REG_RES_BASE = 8'h30;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: hdl/vadd_top.sv
`timescale 1ns/1ps

module vadd_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [vadd_pkg::AXI_AW-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [vadd_pkg::AXI_DW-1:0] wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [vadd_pkg::AXI_AW-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [vadd_pkg::AXI_DW-1:0] rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready
);
    import vadd_pkg::*;

    logic                             start;
    logic                             busy;
    logic                             done;
    logic                             all_done;
    logic [NUM_LANES-1:0][LANE_W-1:0] opa;
    logic [NUM_LANES-1:0][LANE_W-1:0] opb;
    logic [NUM_LANES-1:0][LANE_W:0]   res;

    lane_if lane_bus [NUM_LANES] ();

    axil_regs u_regs (
        .clk     (clk),     .rst_n   (rst_n),
        .awaddr  (awaddr),  .awvalid (awvalid), .awready (awready),
        .wdata   (wdata),   .wvalid  (wvalid),  .wready  (wready),
        .bresp   (bresp),   .bvalid  (bvalid),  .bready  (bready),
        .araddr  (araddr),  .arvalid (arvalid), .arready (arready),
        .rdata   (rdata),   .rresp   (rresp),   .rvalid  (rvalid),
        .rready  (rready),
        .start   (start),   .opa     (opa),     .opb     (opb),
        .busy    (busy),    .done    (done),    .res     (res)
    );

    lane_dispatch u_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .opa      (opa),
        .opb      (opb),
        .all_done (all_done),
        .busy     (busy),
        .lanes    (lane_bus)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        pipe_adder #(.WIDTH(LANE_W)) u_adder (
            .clk   (clk),
            .rst_n (rst_n),
            .lane  (lane_bus[i])
        );
    end

    result_collect u_collect (
        .clk      (clk),
        .rst_n    (rst_n),
        .lanes    (lane_bus),
        .res      (res),
        .done     (done),
        .all_done (all_done)
    );

endmodule

// File: src.f
hdl/vadd_pkg.sv
hdl/lane_if.sv
hdl/axil_regs.sv
hdl/lane_dispatch.sv
hdl/pipe_adder.sv
hdl/result_collect.sv
hdl/vadd_top.sv
test/vadd_sva.sv
test/tb_vadd.sv

// File: test/tb_vadd.sv
`timescale 1ns/1ps

module tb_vadd;
    import vadd_pkg::*;

    localparam int WAIT_LIMIT = 20;  // Cycles allowed for one handshake.
    localparam int POLL_LIMIT = 30;  // STATUS reads before giving up.

    logic              clk;
    logic              rst_n;
    logic [AXI_AW-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [AXI_DW-1:0] wdata;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [AXI_AW-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [AXI_DW-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    int                errors;
    logic [LANE_W-1:0] opa_m [NUM_LANES];  // Operands as last written.
    logic [LANE_W-1:0] opb_m [NUM_LANES];
    logic [LANE_W:0]   exp_m [NUM_LANES];  // Sums of the operands at the last start.

    vadd_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [LANE_W:0] lane_sum(input logic [LANE_W-1:0] a,
                                                 input logic [LANE_W-1:0] b);
        return {1'b0, a} + {1'b0, b};  // Carry lands in bit 16.
    endfunction

    task automatic abort_run(input string why);
        errors++;
        $display("error at %0t: %s", $time, why);
        $display("checks done, errors: %0d", errors);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic compare(input string name, input logic [AXI_DW-1:0] got,
                           input logic [AXI_DW-1:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge clk);
        #1;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready)) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("write address and data never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("write response never arrived");
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);  // bvalid waits one edge on bready.
        #1;
        bready = 1'b1;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data,
                            output logic [1:0] resp);
        int n;
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("read address never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("read data never arrived");
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        repeat ($urandom_range(1, 3)) @(posedge clk);  // Stall with rready low.
        #1;
        rready = 1'b1;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic check_read(input string name, input logic [AXI_AW-1:0] addr,
                              input logic [AXI_DW-1:0] exp, input logic [1:0] exp_resp);
        logic [AXI_DW-1:0] data;
        logic [1:0]        resp;
        axi_read(addr, data, resp);
        compare({name, " rresp"}, AXI_DW'(resp), AXI_DW'(exp_resp));
        if (exp_resp == RESP_OKAY) compare(name, data, exp);
    endtask

    task automatic check_write(input string name, input logic [AXI_AW-1:0] addr,
                               input logic [AXI_DW-1:0] data, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        compare({name, " bresp"}, AXI_DW'(resp), AXI_DW'(exp_resp));
    endtask

    task automatic write_operands(input bit opa_only);
        for (int i = 0; i < NUM_LANES; i++) begin
            check_write($sformatf("OPA[%0d]", i), REG_OPA_BASE + AXI_AW'(4 * i),
                        {16'($urandom), opa_m[i]}, RESP_OKAY);  // Upper half is dropped.
            if (!opa_only) begin
                check_write($sformatf("OPB[%0d]", i), REG_OPB_BASE + AXI_AW'(4 * i),
                            {16'($urandom), opb_m[i]}, RESP_OKAY);
            end
        end
    endtask

    task automatic start_batch();
        for (int i = 0; i < NUM_LANES; i++) exp_m[i] = lane_sum(opa_m[i], opb_m[i]);
        check_write("CTRL", REG_CTRL, 32'h1, RESP_OKAY);
        check_read("STATUS after start", REG_STATUS, 32'h1, RESP_OKAY);  // Busy, done cleared.
    endtask

    task automatic finish_batch();
        logic [AXI_DW-1:0] status;
        logic [1:0]        resp;
        int                polls;
        polls = 0;
        axi_read(REG_STATUS, status, resp);
        while (!status[1]) begin
            polls++;
            if (polls > POLL_LIMIT) abort_run("done never showed in STATUS");
            axi_read(REG_STATUS, status, resp);
        end
        check_read("STATUS after run", REG_STATUS, 32'h2, RESP_OKAY);
        for (int i = 0; i < NUM_LANES; i++) begin
            check_read($sformatf("RES[%0d]", i), REG_RES_BASE + AXI_AW'(4 * i),
                       AXI_DW'(exp_m[i]), RESP_OKAY);
        end
    endtask

    task automatic random_operands();
        for (int i = 0; i < NUM_LANES; i++) begin
            opa_m[i] = LANE_W'($urandom);
            opb_m[i] = LANE_W'($urandom);
        end
    endtask

    initial begin
        errors  = 0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(78734));
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_read("STATUS", REG_STATUS, 32'h0, RESP_OKAY);
        for (int i = 0; i < NUM_LANES; i++) begin
            check_read($sformatf("RES[%0d]", i), REG_RES_BASE + AXI_AW'(4 * i), 32'h0, RESP_OKAY);
        end

        // Register access rules.
        random_operands();
        write_operands(1'b0);
        for (int i = 0; i < NUM_LANES; i++) begin
            check_read($sformatf("OPA[%0d]", i), REG_OPA_BASE + AXI_AW'(4 * i),
                       AXI_DW'(opa_m[i]), RESP_OKAY);
            check_read($sformatf("OPB[%0d]", i), REG_OPB_BASE + AXI_AW'(4 * i),
                       AXI_DW'(opb_m[i]), RESP_OKAY);
        end
        check_write("RES[0]", REG_RES_BASE, 32'hdead_beef, RESP_OKAY);
        check_read("RES[0]", REG_RES_BASE, 32'h0, RESP_OKAY);
        check_write("offset 0x08", 8'h08, 32'h1, RESP_SLVERR);
        check_read("offset 0x08", 8'h08, 32'h0, RESP_SLVERR);
        check_read("offset 0x40", 8'h40, 32'h0, RESP_SLVERR);

        repeat (5) begin
            random_operands();
            write_operands(1'b0);
            start_batch();
            finish_batch();
        end

        // Carry extremes, one per lane.
        opa_m = '{16'hffff, 16'hffff, 16'h0000, LANE_W'($urandom)};
        opb_m = '{16'hffff, 16'h0001, 16'h0000, LANE_W'($urandom)};
        write_operands(1'b0);
        start_batch();
        finish_batch();

        // OPA rewritten mid-run must not reach the lanes until the next start.
        random_operands();
        write_operands(1'b0);
        start_batch();
        for (int i = 0; i < NUM_LANES; i++) opa_m[i] = LANE_W'($urandom);
        write_operands(1'b1);
        finish_batch();
        start_batch();
        finish_batch();

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: test/vadd_sva.sv
`timescale 1ns/1ps

module vadd_sva (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        issue,
    input logic                        sum_valid,
    input logic                        bvalid,
    input logic                        bready,
    input logic                        rvalid,
    input logic                        rready,
    input logic [vadd_pkg::AXI_DW-1:0] rdata
);
    import vadd_pkg::*;

    // A lane result only appears for an addition issued ADD_LAT cycles before.
    a_sum_latency: assert property (@(posedge clk) disable iff (!rst_n)
        sum_valid |-> $past(issue, ADD_LAT))
        else $error("sum_valid without an issue %0d cycles earlier", ADD_LAT);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Read data must not move while the master stalls.
    a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> $stable(rdata))
        else $error("rdata changed while rvalid waited");

endmodule

bind pipe_adder vadd_sva u_lane_sva (
    .clk    (clk),        .rst_n     (rst_n),
    .issue  (lane.issue), .sum_valid (lane.sum_valid),
    .bvalid (1'b0),       .bready    (1'b0),
    .rvalid (1'b0),       .rready    (1'b0),
    .rdata  (32'h0)
);

bind axil_regs vadd_sva u_bus_sva (
    .clk    (clk),    .rst_n     (rst_n),
    .issue  (1'b0),   .sum_valid (1'b0),
    .bvalid (bvalid), .bready    (bready),
    .rvalid (rvalid), .rready    (rready),
    .rdata  (rdata)
);
